// ==== Makefile ====
# Verilator build and run for the dual-clock FIFO testbench
TOP = txdp_fifo_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f -Mdir obj_dir

run: compile
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "No verdict in $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/txdp_bitsync.sv ====
// Flop chain that brings a Gray-coded bus into the destination clock
// Source must change by at most one bit per source clock edge
`timescale 1ns/1ps
`default_nettype none

`include "txdp_fifo_macros.svh"

module txdp_bitsync #(
   parameter int WIDTH = 5                       // Bus width
) (
   input  wire              clk,                 // Destination clock
   input  wire              rst_n,               // Destination reset, sync
   input  wire  [WIDTH-1:0] data_in,             // From source domain
   output logic [WIDTH-1:0] data_out             // Settled copy
);

   localparam int STAGES = `TXDP_SYNC_STAGES;

   // Stage 0 is the metastable catcher
   logic [WIDTH-1:0] sync_q [STAGES];

   // ******************************
   // Shift chain
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < STAGES; i++) begin
            sync_q[i] <= '0;                     // All stages cleared
         end
      end else begin
         sync_q[0] <= data_in;
         for (int i = 1; i < STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];            // Move down the chain
         end
      end
   end

   // Last stage only
   assign data_out = sync_q[STAGES-1];

endmodule

`default_nettype wire

// ==== hdl/txdp_fifo_flow.sv ====
// Flag generation, enable gating and the registered FIFO output
// Sits between the raw strobes and the pointer and storage blocks
`timescale 1ns/1ps
`default_nettype none

`include "txdp_fifo_macros.svh"

module txdp_fifo_flow (
   input  wire                     wr_clk,       // Write domain clock
   input  wire                     wr_rst_n,     // Synchronous write domain reset
   input  wire                     rd_clk,       // Read domain clock
   input  wire                     rd_rst_n,     // Synchronous read domain reset
   input  wire                     wr_en,        // Raw write strobe
   input  wire                     rd_en,        // Raw read strobe
   input  txdp_fifo_pkg::wr_side_t wr_side,      // Write domain count
   input  txdp_fifo_pkg::rd_side_t rd_side,      // Read domain count
   input  txdp_fifo_pkg::data_t    rd_word,      // Head word from storage
   output logic                    wr_push,      // Gated write
   output logic                    rd_pop,       // Gated read
   output logic                    full,         // Write side level
   output logic                    empty,        // Read side level
   output txdp_fifo_pkg::rd_out_t  rd_out        // Word and valid pulse
);

   import txdp_fifo_pkg::*;

   // Output register
   logic  rd_valid_q;
   data_t rd_data_q;

   // ******************************
   // Gating
   // ******************************
   // Drop writes when full and reads when empty
   assign wr_push = wr_en & ~full;
   assign rd_pop  = rd_en & ~empty;

   // ******************************
   // Full flag in the write domain
   // ******************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         full <= 1'b0;
      end else begin
         full <= (wr_side.wr_numdata == count_t'(`TXDP_DEPTH - 1));  // Next state
      end
   end

   // ******************************
   // Empty flag in the read domain
   // ******************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         empty <= 1'b1;                          // Nothing stored yet
      end else begin
         empty <= (rd_side.rd_numdata == '0);
      end
   end

   // ******************************
   // Read output
   // ******************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= rd_pop;                   // One cycle per pop
      end
   end

   // Data holds between pops
   always_ff @(posedge rd_clk) begin
      if (rd_pop) begin
         rd_data_q <= rd_word;
      end
   end

   assign rd_out = '{rd_valid: rd_valid_q, rd_data: rd_data_q};

   // ******************************
   // Checks
   // ******************************
   // A pop never moves the read pointer past the synced write pointer
   a_pop_no_overrun: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      rd_pop |-> (rd_side.rd_numdata != count_t'(`TXDP_DEPTH - 1)));

endmodule

`default_nettype wire

// ==== hdl/txdp_fifo_macros.svh ====
// Size constants for the dual-clock transmit datapath FIFO
// Included by the package and by any module that sizes logic from them
`ifndef TXDP_FIFO_MACROS_SVH
`define TXDP_FIFO_MACROS_SVH

// ******************************
// Storage geometry
// ******************************
`define TXDP_AWIDTH 4                    // Address bits into the array
`define TXDP_DEPTH 16                    // 2**TXDP_AWIDTH entries
                                         // Usable depth is one less

// ******************************
// Datapath
// ******************************
`define TXDP_DWIDTH 40                   // Word width

// ******************************
// Clock crossing
// ******************************
`define TXDP_SYNC_STAGES 2               // Flops per Gray synchronizer
                                         // Raise for faster clocks

`endif

// ==== hdl/txdp_fifo_mem.sv ====
// Register-array storage for the FIFO words, no reset on the payload
// Written by one-hot select on wr_clk, read combinationally by address
`timescale 1ns/1ps
`default_nettype none

`include "txdp_fifo_macros.svh"

module txdp_fifo_mem (
   input  wire                    wr_clk,        // Write domain clock
   input  wire                    wr_push,       // Accepted write
   input  txdp_fifo_pkg::onehot_t wr_sel,        // Entry to load
   input  txdp_fifo_pkg::data_t   wr_data,       // Incoming word
   input  txdp_fifo_pkg::addr_t   rd_addr,       // Head entry
   output txdp_fifo_pkg::data_t   rd_word        // Word at head
);

   import txdp_fifo_pkg::*;

   // ******************************
   // Entries
   // ******************************
   data_t mem_q [`TXDP_DEPTH];

   // Per-entry load enable
   onehot_t load;

   assign load = wr_sel & {`TXDP_DEPTH{wr_push}};

   always_ff @(posedge wr_clk) begin
      for (int i = 0; i < `TXDP_DEPTH; i++) begin
         if (load[i]) begin
            mem_q[i] <= wr_data;                 // Only the selected entry
         end
      end
   end

   // ******************************
   // Read mux
   // ******************************
   // Head entry is stable here, written at least one sync delay earlier
   assign rd_word = mem_q[rd_addr];

   // ******************************
   // Checks
   // ******************************
   // Pointer decode must give exactly one entry on a push
   a_sel_onehot: assert property (@(posedge wr_clk)
      wr_push |-> $onehot(wr_sel));

endmodule

`default_nettype wire

// ==== hdl/txdp_fifo_pkg.sv ====
// Shared types for the transmit datapath FIFO blocks
// Import wherever pointers, counts or the side structs are needed
`default_nettype none

`include "txdp_fifo_macros.svh"

package txdp_fifo_pkg;

   // ******************************
   // Vector types
   // ******************************
   typedef logic [`TXDP_AWIDTH-1:0] addr_t;     // Storage index
   typedef logic [`TXDP_AWIDTH:0]   ptr_t;      // Index plus wrap bit
   typedef logic [`TXDP_DEPTH-1:0]  onehot_t;   // Decoded write select
   typedef logic [`TXDP_AWIDTH-1:0] count_t;    // Occupancy, max DEPTH-1
   typedef logic [`TXDP_DWIDTH-1:0] data_t;     // FIFO word

   // ******************************
   // Block-to-block bundles
   // ******************************
   // Write domain view from the pointer block
   typedef struct packed {
      onehot_t wr_sel;                           // Entry to load
      count_t  wr_numdata;                       // Next wr ptr vs synced rd ptr
   } wr_side_t;

   // Read domain view from the pointer block
   typedef struct packed {
      addr_t  rd_addr;                           // Entry at head
      count_t rd_numdata;                        // Synced wr ptr vs next rd ptr
   } rd_side_t;

   // FIFO output word with its strobe
   typedef struct packed {
      logic  rd_valid;                           // One cycle per pop
      data_t rd_data;                            // Held until next pop
   } rd_out_t;

endpackage

`default_nettype wire

// ==== hdl/txdp_fifo_ptr.sv ====
// Write and read pointers with Gray crossing and per-domain occupancy
// Drives the storage select and address plus counts for the flags
`timescale 1ns/1ps
`default_nettype none

`include "txdp_fifo_macros.svh"

module txdp_fifo_ptr (
   input  wire                     wr_clk,       // Write domain clock
   input  wire                     wr_rst_n,     // Write domain reset, sync
   input  wire                     rd_clk,       // Read domain clock
   input  wire                     rd_rst_n,     // Read domain reset, sync
   input  wire                     wr_push,      // Accepted write
   input  wire                     rd_pop,       // Accepted read
   output txdp_fifo_pkg::wr_side_t wr_side,      // Select and write count
   output txdp_fifo_pkg::rd_side_t rd_side       // Address and read count
);

   import txdp_fifo_pkg::*;

   localparam int AW = `TXDP_AWIDTH;

   // Write domain pointers
   ptr_t wr_bin_q, wr_gry_q;
   ptr_t wr_bin_nxt, wr_gry_nxt;
   ptr_t rd_gry_sync, rd_bin_sync;               // Read ptr seen on wr_clk

   // Read domain pointers
   ptr_t rd_bin_q, rd_gry_q;
   ptr_t rd_bin_nxt, rd_gry_nxt;
   ptr_t wr_gry_sync, wr_bin_sync;               // Write ptr seen on rd_clk

   // ******************************
   // Helpers
   // ******************************
   function automatic ptr_t bin_to_gray(input ptr_t b);
      return b ^ (b >> 1);
   endfunction

   function automatic ptr_t gray_to_bin(input ptr_t g);
      ptr_t b;
      b[AW] = g[AW];                             // MSB passes straight
      for (int i = AW - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];                   // Running XOR down
      end
      return b;
   endfunction

   function automatic onehot_t bin_to_onehot(input addr_t a);
      onehot_t oh;
      oh    = '0;
      oh[a] = 1'b1;
      return oh;
   endfunction

   // ******************************
   // Write clock domain
   // ******************************
   assign wr_bin_nxt = wr_bin_q + ptr_t'(wr_push);
   assign wr_gry_nxt = bin_to_gray(wr_bin_nxt);

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_bin_q <= '0;
         wr_gry_q <= '0;
      end else begin
         wr_bin_q <= wr_bin_nxt;
         wr_gry_q <= wr_gry_nxt;                 // Registered before crossing
      end
   end

   // Read pointer into write domain
   txdp_bitsync #(.WIDTH(AW + 1)) i_sync_rd2wr (
      .clk      (wr_clk),
      .rst_n    (wr_rst_n),
      .data_in  (rd_gry_q),
      .data_out (rd_gry_sync)
   );

   assign rd_bin_sync = gray_to_bin(rd_gry_sync);

   // Count after this cycle's push, so full can register in time
   assign wr_side = '{wr_sel:     bin_to_onehot(wr_bin_q[AW-1:0]),
                      wr_numdata: count_t'(wr_bin_nxt - rd_bin_sync)};

   // ******************************
   // Read clock domain
   // ******************************
   assign rd_bin_nxt = rd_bin_q + ptr_t'(rd_pop);
   assign rd_gry_nxt = bin_to_gray(rd_bin_nxt);

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_bin_q <= '0;
         rd_gry_q <= '0;
      end else begin
         rd_bin_q <= rd_bin_nxt;
         rd_gry_q <= rd_gry_nxt;
      end
   end

   // Write pointer into read domain
   txdp_bitsync #(.WIDTH(AW + 1)) i_sync_wr2rd (
      .clk      (rd_clk),
      .rst_n    (rd_rst_n),
      .data_in  (wr_gry_q),
      .data_out (wr_gry_sync)
   );

   assign wr_bin_sync = gray_to_bin(wr_gry_sync);

   assign rd_side = '{rd_addr:    rd_bin_q[AW-1:0],     // Head entry
                      rd_numdata: count_t'(wr_bin_sync - rd_bin_nxt)};

   // ******************************
   // Checks
   // ******************************
   // Crossing is only safe with single-bit steps
   a_wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      $countones(wr_gry_q ^ $past(wr_gry_q)) <= 1);
   a_rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      $countones(rd_gry_q ^ $past(rd_gry_q)) <= 1);

   // Flow stage must stop pushing once DEPTH-1 is held
   a_no_push_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      (wr_side.wr_numdata == count_t'(`TXDP_DEPTH - 1)) |=> !wr_push);

endmodule

`default_nettype wire

// ==== hdl/txdp_fifo_top.sv ====
// Dual-clock transmit datapath FIFO, write on wr_clk and read on rd_clk
// Instantiate this block; full and empty are levels in their own domains
`timescale 1ns/1ps
`default_nettype none

module txdp_fifo_top (
   input  wire                    wr_clk,        // Write domain clock
   input  wire                    wr_rst_n,      // Write domain reset, sync
   input  wire                    rd_clk,        // Read domain clock
   input  wire                    rd_rst_n,      // Read domain reset, sync
   input  wire                    wr_en,         // Write strobe
   input  txdp_fifo_pkg::data_t   wr_data,       // Write word
   input  wire                    rd_en,         // Read strobe
   output logic                   full,          // Write side, DEPTH-1 held
   output logic                   empty,         // Read side, nothing held
   output txdp_fifo_pkg::rd_out_t rd_out         // Popped word and valid
);

   import txdp_fifo_pkg::*;

   // ******************************
   // Internal nets
   // ******************************
   logic     wr_push;                            // Write past the gate
   logic     rd_pop;                             // Read past the gate
   wr_side_t wr_side;
   rd_side_t rd_side;
   data_t    rd_word;                            // Head word

   // ******************************
   // Pointers and crossing
   // ******************************
   txdp_fifo_ptr i_txdp_fifo_ptr (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .wr_push  (wr_push),
      .rd_pop   (rd_pop),
      .wr_side  (wr_side),
      .rd_side  (rd_side)
   );

   // ******************************
   // Storage
   // ******************************
   txdp_fifo_mem i_txdp_fifo_mem (
      .wr_clk  (wr_clk),
      .wr_push (wr_push),
      .wr_sel  (wr_side.wr_sel),
      .wr_data (wr_data),
      .rd_addr (rd_side.rd_addr),
      .rd_word (rd_word)
   );

   // ******************************
   // Flags and output
   // ******************************
   txdp_fifo_flow i_txdp_fifo_flow (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .wr_en    (wr_en),
      .rd_en    (rd_en),
      .wr_side  (wr_side),
      .rd_side  (rd_side),
      .rd_word  (rd_word),
      .wr_push  (wr_push),
      .rd_pop   (rd_pop),
      .full     (full),
      .empty    (empty),
      .rd_out   (rd_out)
   );

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/txdp_fifo_pkg.sv
hdl/txdp_bitsync.sv
hdl/txdp_fifo_ptr.sv
hdl/txdp_fifo_mem.sv
hdl/txdp_fifo_flow.sv
hdl/txdp_fifo_top.sv
test/tb_clkgen.sv
test/txdp_fifo_tb.sv

// ==== test/tb_clkgen.sv ====
// Clock and reset source for the FIFO testbench
// Two unaligned 10 ns clocks, each reset released after 16 of its own cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic wr_clk,                          // Write domain clock
   output logic rd_clk,                          // Read domain clock
   output logic wr_rst_n,                        // Write domain reset
   output logic rd_rst_n                         // Read domain reset
);

   localparam int HALF       = 5;                // 10 ns period
   localparam int WR_OFFSET  = 3;                // Keeps the two edges apart
   localparam int RST_CYCLES = 16;

   initial begin
      rd_clk = 1'b0;
      forever #HALF rd_clk = ~rd_clk;
   end

   initial begin
      wr_clk = 1'b0;
      #WR_OFFSET;
      forever begin
         wr_clk = 1'b1;
         #HALF;
         wr_clk = 1'b0;
         #HALF;
      end
   end

   // Release on a falling edge, clear of the sampling edge
   initial begin
      rd_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge rd_clk);
      @(negedge rd_clk);
      rd_rst_n = 1'b1;
   end

   initial begin
      wr_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge wr_clk);
      @(negedge wr_clk);
      wr_rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== test/txdp_fifo_tb.sv ====
// Testbench for the dual-clock FIFO with random strobes in both domains and a queue model
// Compiled through project.f; the run ends with a single verdict line
`timescale 1ns/1ps
`default_nettype none

`include "txdp_fifo_macros.svh"

module txdp_fifo_tb;

   import txdp_fifo_pkg::*;

   localparam int SEED       = 70445;
   localparam int N_WRITES   = 3000;             // Accepted writes before the drain
   localparam int PHASE_LEN  = 400;              // rd_clk cycles per rate phase
   localparam int MAX_CYCLES = 60000;            // About ten times a normal run
   localparam int HELD_MAX   = `TXDP_DEPTH - 1;  // Usable entries
   localparam int SETTLE     = 2 * `TXDP_SYNC_STAGES + 8;

   logic    wr_clk, rd_clk;
   logic    wr_rst_n, rd_rst_n;
   logic    wr_en   = 1'b0;
   logic    rd_en   = 1'b0;
   data_t   wr_data = '0;
   logic    full, empty;
   rd_out_t rd_out;

   // ******************************
   // Model state
   // ******************************
   data_t model_q [$];                           // Accepted, not yet popped
   data_t exp_word    = '0;                      // Last popped word
   logic  pop_pending = 1'b0;                    // Pop decided one rd cycle ago
   logic  idle        = 1'b1;                    // No write offered yet
   int    wr_rate     = 0;                       // Strobe rates in percent
   int    rd_rate     = 0;
   int    n_accepted  = 0;
   int    n_checked   = 0;
   int    rd_cycles   = 0;
   int    phase       = 0;

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_data(input data_t expected, input data_t observed);
      if (observed !== expected) begin
         stop_run($sformatf("Error at %0t: rd_data %h, expected %h",
                            $time, observed, expected));
      end
   endtask

   task automatic check_flag(input string what, input logic expected, input logic observed);
      if (observed !== expected) begin
         stop_run($sformatf("Error at %0t: %s is %b, expected %b",
                            $time, what, observed, expected));
      end
   endtask

   // Bound check, or exact match when exact is set
   task automatic check_count(input string what, input count_t lim, input int occ,
                              input bit exact);
      if (exact ? (occ != int'(lim)) : (occ > int'(lim))) begin
         stop_run($sformatf("Error at %0t: %s is %0d, limit %0d", $time, what, occ, lim));
      end
   endtask

   tb_clkgen i_clkgen (
      .wr_clk   (wr_clk),
      .rd_clk   (rd_clk),
      .wr_rst_n (wr_rst_n),
      .rd_rst_n (rd_rst_n)
   );

   txdp_fifo_top i_txdp_fifo_top (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .wr_en    (wr_en),
      .wr_data  (wr_data),
      .rd_en    (rd_en),
      .full     (full),
      .empty    (empty),
      .rd_out   (rd_out)
   );

   // ******************************
   // Write side driver and model
   // ******************************
   always @(negedge wr_clk) begin : drive_wr
      logic offer;
      if (wr_rst_n) begin
         if (idle) begin
            check_flag("full before first write", 1'b0, full);
         end
         offer   = ($urandom % 100) < wr_rate;
         wr_en   = offer;
         wr_data = data_t'({$urandom, $urandom});
         if (offer) begin
            idle = 1'b0;
         end
         // full settled on the last rising edge, so this predicts the push
         if (offer && !full) begin
            model_q.push_back(wr_data);
            n_accepted++;
         end
         check_count("model occupancy", count_t'(HELD_MAX), model_q.size(), 1'b0);
      end
   end

   // ******************************
   // Read side driver and checker
   // ******************************
   always @(negedge rd_clk) begin : drive_rd
      logic offer;
      if (rd_rst_n) begin
         check_flag("rd_valid", pop_pending, rd_out.rd_valid);   // One pulse per pop
         if (pop_pending) begin
            n_checked++;
         end
         if (n_checked > 0) begin
            check_data(exp_word, rd_out.rd_data);   // Also covers the hold
         end
         if (idle) begin
            check_flag("empty before first write", 1'b1, empty);
         end
         offer       = ($urandom % 100) < rd_rate;
         rd_en       = offer;
         pop_pending = offer && !empty;
         if (pop_pending) begin
            if (model_q.size() == 0) begin
               stop_run("DUT accepted a read while the model queue was empty");
            end
            exp_word = model_q.pop_front();
         end
      end
   end

   // Run limit
   always @(posedge rd_clk) begin
      rd_cycles++;
      if (rd_cycles >= MAX_CYCLES) begin
         stop_run($sformatf("Run did not finish within %0d read clock cycles", MAX_CYCLES));
      end
   end

   // ******************************
   // Sequence
   // ******************************
   initial begin
      void'($urandom(SEED));
      wait (wr_rst_n && rd_rst_n);
      repeat (20) @(posedge rd_clk);             // Reset levels watched here

      // Rates change on rising edges, away from the drivers
      while (n_accepted < N_WRITES) begin
         case (phase % 3)
            0: begin
               wr_rate = 90;                     // Write heavy, reaches full
               rd_rate = 25;
            end
            1: begin
               wr_rate = 25;                     // Read heavy, reaches empty
               rd_rate = 90;
            end
            default: begin
               wr_rate = 60;
               rd_rate = 60;
            end
         endcase
         repeat (PHASE_LEN) @(posedge rd_clk);
         phase++;
      end

      // Reads stopped, let the read pointer cross, then fill up
      wr_rate = 0;
      rd_rate = 0;
      repeat (SETTLE) @(posedge rd_clk);
      wr_rate = 100;
      while (!full) begin
         @(posedge rd_clk);                      // full stable here
      end
      repeat (SETTLE) @(posedge rd_clk);
      check_flag("full with reads stopped", 1'b1, full);
      check_count("model occupancy when full", count_t'(HELD_MAX), model_q.size(), 1'b1);

      // Writes stopped, drain everything
      wr_rate = 0;
      rd_rate = 100;
      @(posedge wr_clk);
      while (!(empty && model_q.size() == 0)) begin
         @(posedge wr_clk);                      // empty stable here
      end
      repeat (SETTLE) @(posedge wr_clk);
      check_flag("empty after drain", 1'b1, empty);
      check_count("model occupancy after drain", count_t'(0), model_q.size(), 1'b1);

      if (n_checked == n_accepted) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         stop_run($sformatf("Only %0d of %0d accepted words came out", n_checked, n_accepted));
      end
   end

endmodule

`default_nettype wire
